// ==== rtl/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// architectural register file size
`define MIPS_REG_COUNT 32

// register address width follows the register count
`define MIPS_REG_AW $clog2(`MIPS_REG_COUNT)

// data path width, one word
`define MIPS_XLEN 32

// immediate field width of the I-type format
`define MIPS_IMM_W 16

`endif

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // primary opcode, bits 31:26
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,  // R-type, resolved by funct
        OP_SPECIAL2 = 6'b011100,  // mul
        OP_SPECIAL3 = 6'b011111,  // seb / seh through BSHFL
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110
    } opcodeE;

    // funct, bits 5:0
    typedef enum logic [5:0] {
        FN_MUL  = 6'b000010,  // SPECIAL2 group
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functE;

    // BSHFL sits on the same funct code as add
    localparam functE FN_BSHFL = FN_ADD;

    // sa field picks the BSHFL variant
    localparam logic [4:0] SA_SEB = 5'b10000;
    localparam logic [4:0] SA_SEH = 5'b11000;

    ////////////////////////////////////////////////////////////////////////////
    // resolved ALU operation
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_RSVD = 4'b0000,  // no operation, illegal encodings
        ALU_ADD  = 4'b0001,
        ALU_SUB  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_XOR  = 4'b0101,
        ALU_NOR  = 4'b0110,
        ALU_SLT  = 4'b1010,
        ALU_SLTU = 4'b1011,
        ALU_MUL  = 4'b1100,
        ALU_SEB  = 4'b1101,
        ALU_SEH  = 4'b1110
    } aluOpE;

endpackage

// ==== rtl/ctrlIf.sv ====
`timescale 1ns/1ps

// decoded control levels, controller to datapath
interface ctrlIf;
    import mips_pkg::*;

    logic  regWrite;  // instruction writes back
    logic  regDst;    // dest from rd, else rt
    logic  aluSrc;    // operand B is the immediate
    logic  signExt;   // sign-extend the immediate
    aluOpE aluOp;
    logic  illegal;   // unsupported encoding

    modport controller (
        output regWrite, regDst, aluSrc, signExt, aluOp, illegal
    );

    modport datapath (
        input regWrite, regDst, aluSrc, signExt, aluOp, illegal
    );

endinterface

// ==== rtl/datapathController.sv ====
`timescale 1ns/1ps

module datapathController (
    input  mips_pkg::opcodeE opcode,
    input  mips_pkg::functE  funct,
    input  logic [4:0]       shamt,
    ctrlIf.controller        ctrl
);
    import mips_pkg::*;

    aluOpE specialOp;
    logic  specialOk;

    ////////////////////////////////////////////////////////////////////////////
    // SPECIAL group, funct to ALU operation
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin : specialDecode
        specialOk = 1'b1;
        case (funct)
            FN_ADD, FN_ADDU: specialOp = ALU_ADD;  // add wraps, no trap
            FN_SUB, FN_SUBU: specialOp = ALU_SUB;
            FN_AND:          specialOp = ALU_AND;
            FN_OR:           specialOp = ALU_OR;
            FN_XOR:          specialOp = ALU_XOR;
            FN_NOR:          specialOp = ALU_NOR;
            FN_SLT:          specialOp = ALU_SLT;
            FN_SLTU:         specialOp = ALU_SLTU;
            default: begin
                specialOp = ALU_RSVD;
                specialOk = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // main decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin : mainDecode
        // idle values, anything not matched below stays illegal
        ctrl.regWrite = 1'b0;
        ctrl.regDst   = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.signExt  = 1'b0;
        ctrl.aluOp    = ALU_RSVD;
        ctrl.illegal  = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                ctrl.regDst   = 1'b1;
                ctrl.aluOp    = specialOp;
                ctrl.regWrite = specialOk;
                ctrl.illegal  = !specialOk;
            end
            OP_SPECIAL2: begin
                if (funct == FN_MUL) begin
                    ctrl.regDst   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = ALU_MUL;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_SPECIAL3: begin
                ctrl.regDst = 1'b1;
                if (funct == FN_BSHFL && shamt == SA_SEB) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = ALU_SEB;
                end else if (funct == FN_BSHFL && shamt == SA_SEH) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = ALU_SEH;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_ADDI, OP_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_SLTI, OP_SLTIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.signExt  = 1'b1;  // sltiu still sign-extends, then compares unsigned
                ctrl.aluOp    = (opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
            end
            OP_ANDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_AND;
            end
            OP_ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_OR;
            end
            OP_XORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_XOR;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`MIPS_REG_AW-1:0] rsAddr,
    input  logic [`MIPS_REG_AW-1:0] rtAddr,
    output logic [`MIPS_XLEN-1:0]   rsData,
    output logic [`MIPS_XLEN-1:0]   rtData,
    input  logic                    wrEn,
    input  logic [`MIPS_REG_AW-1:0] wrAddr,
    input  logic [`MIPS_XLEN-1:0]   wrData
);

    // r0 has no storage
    logic [`MIPS_XLEN-1:0] regs [1:`MIPS_REG_COUNT-1];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;  // writes to r0 are dropped
        end
    end

    // asynchronous reads, r0 reads as zero
    always_comb begin
        if (rsAddr == '0) begin
            rsData = '0;
        end else begin
            rsData = regs[rsAddr];
        end
    end

    always_comb begin
        if (rtAddr == '0) begin
            rtData = '0;
        end else begin
            rtData = regs[rtAddr];
        end
    end

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module aluUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  logic [`MIPS_XLEN-1:0]   rsData,
    input  logic [`MIPS_XLEN-1:0]   rtData,
    input  logic [`MIPS_IMM_W-1:0]  imm,
    input  logic [`MIPS_REG_AW-1:0] rtAddr,
    input  logic [`MIPS_REG_AW-1:0] rdAddr,
    ctrlIf.datapath                 ctrl,
    output logic                    wrEn,
    output logic [`MIPS_REG_AW-1:0] wrAddr,
    output logic [`MIPS_XLEN-1:0]   wrData,
    output logic                    wbValid,
    output logic                    illegal,
    output logic [`MIPS_REG_AW-1:0] wbAddr,
    output logic [`MIPS_XLEN-1:0]   wbData
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0]   immExt;
    logic [`MIPS_XLEN-1:0]   opB;
    logic [`MIPS_XLEN-1:0]   aluRes;
    logic [`MIPS_REG_AW-1:0] dstAddr;

    ////////////////////////////////////////////////////////////////////////////
    // operand path
    ////////////////////////////////////////////////////////////////////////////
    assign immExt = ctrl.signExt ? {{(`MIPS_XLEN-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm}
                                 : {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm};
    assign opB     = ctrl.aluSrc ? immExt : rtData;
    assign dstAddr = ctrl.regDst ? rdAddr : rtAddr;  // I-type writes rt

    always_comb begin : aluOps
        case (ctrl.aluOp)
            ALU_ADD:  aluRes = rsData + opB;  // wraps on overflow
            ALU_SUB:  aluRes = rsData - opB;
            ALU_AND:  aluRes = rsData & opB;
            ALU_OR:   aluRes = rsData | opB;
            ALU_XOR:  aluRes = rsData ^ opB;
            ALU_NOR:  aluRes = ~(rsData | opB);
            ALU_SLT:  aluRes = {{(`MIPS_XLEN-1){1'b0}}, ($signed(rsData) < $signed(opB))};
            ALU_SLTU: aluRes = {{(`MIPS_XLEN-1){1'b0}}, (rsData < opB)};
            // low word of the product is the same signed or unsigned
            ALU_MUL:  aluRes = rsData * opB;
            ALU_SEB:  aluRes = {{(`MIPS_XLEN-8){rtData[7]}}, rtData[7:0]};
            ALU_SEH:  aluRes = {{(`MIPS_XLEN-16){rtData[15]}}, rtData[15:0]};
            default:  aluRes = '0;
        endcase
    end

    // register file write lands on the issue edge
    assign wrEn   = instrValid & ctrl.regWrite;
    assign wrAddr = dstAddr;
    assign wrData = aluRes;

    ////////////////////////////////////////////////////////////////////////////
    // writeback report, one cycle after issue
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            illegal <= 1'b0;
            wbAddr  <= '0;
            wbData  <= '0;
        end else begin
            wbValid <= wrEn;
            illegal <= instrValid & ctrl.illegal;
            if (wrEn) begin
                wbAddr <= dstAddr;
                wbData <= aluRes;  // r0 target still reports the computed value
            end
        end
    end

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module aluCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  logic [`MIPS_XLEN-1:0]   instr,
    output logic                    wbValid,
    output logic [`MIPS_REG_AW-1:0] wbAddr,
    output logic [`MIPS_XLEN-1:0]   wbData,
    output logic                    illegal
);
    import mips_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////
    opcodeE                  opcode;
    functE                   funct;
    logic [4:0]              shamt;
    logic [`MIPS_REG_AW-1:0] rsAddr;
    logic [`MIPS_REG_AW-1:0] rtAddr;
    logic [`MIPS_REG_AW-1:0] rdAddr;
    logic [`MIPS_IMM_W-1:0]  imm;

    assign opcode = opcodeE'(instr[31:26]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign shamt  = instr[10:6];   // sa, BSHFL variant
    assign funct  = functE'(instr[5:0]);
    assign imm    = instr[15:0];

    // datapath nets
    logic [`MIPS_XLEN-1:0]   rsData;
    logic [`MIPS_XLEN-1:0]   rtData;
    logic                    wrEn;
    logic [`MIPS_REG_AW-1:0] wrAddr;
    logic [`MIPS_XLEN-1:0]   wrData;

    ctrlIf ctrlBus ();

    datapathController u_ctrl (
        .opcode (opcode),
        .funct  (funct),
        .shamt  (shamt),
        .ctrl   (ctrlBus.controller)
    );

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    aluUnit u_alu (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .rsData     (rsData),
        .rtData     (rtData),
        .imm        (imm),
        .rtAddr     (rtAddr),
        .rdAddr     (rdAddr),
        .ctrl       (ctrlBus.datapath),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .wbValid    (wbValid),
        .illegal    (illegal),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

endmodule

// ==== verif/aluCore_props.sv ====
`timescale 1ns/1ps

module aluCore_props (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input logic wbValid,
    input logic illegal
);

    int failCount = 0;

    ////////////////////////////////////////////////////////////////////////////
    // writeback report protocol
    ////////////////////////////////////////////////////////////////////////////
    oneReportKind: assert property (@(posedge clk) disable iff (!rstN)
        !(wbValid && illegal))
    else begin
        failCount++;
        $error("wbValid and illegal high in the same cycle");
    end

    // every issue is answered on the next edge
    reportFollowsIssue: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |=> (wbValid ^ illegal))
    else begin
        failCount++;
        $error("instrValid not followed by exactly one report");
    end

    noOrphanReport: assert property (@(posedge clk) disable iff (!rstN)
        (wbValid || illegal) |-> $past(instrValid))
    else begin
        failCount++;
        $error("report without a preceding instrValid");
    end

    quietInReset: assert property (@(posedge clk)
        (!rstN && $past(!rstN)) |-> (!wbValid && !illegal))  // settled reset only
    else begin
        failCount++;
        $error("report outputs active during reset");
    end

endmodule

// ==== verif/aluCoreTb.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module aluCoreTb;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int NREG         = `MIPS_REG_COUNT;
    localparam int ROUNDS_ARITH = 6;
    localparam int ROUNDS_IMM   = 6;
    localparam int ROUNDS_MUL   = 6;
    localparam int CHAIN_LEN    = 12;
    localparam int NUM_TESTS    = 6;
    // instructions issued per test, in test order
    localparam int TOTAL_INSTR  = (NREG + 2) + ROUNDS_ARITH * 14 + ROUNDS_IMM * 8
                                + ROUNDS_MUL * 9 + (1 + CHAIN_LEN * 2) + (8 + NREG - 1);

    typedef struct packed {
        logic                    illegal;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   data;
        logic [31:0]             cycle;   // issue cycle
    } expectT;

    logic                    clk        = 1'b0;
    logic                    rstN       = 1'b0;
    logic                    instrValid = 1'b0;
    logic [`MIPS_XLEN-1:0]   instr      = '0;
    logic                    wbValid;
    logic [`MIPS_REG_AW-1:0] wbAddr;
    logic [`MIPS_XLEN-1:0]   wbData;
    logic                    illegal;

    logic [`MIPS_XLEN-1:0] shadow [NREG];  // architectural state as the model sees it
    expectT                expQ [$];
    integer                seed         = 32'h469f;
    int                    cycleCount   = 0;
    int                    checkCount   = 0;
    int                    errorCount   = 0;
    int                    testErrStart = 0;

    functE  arithFn [10] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                             FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    opcodeE immOp [7]    = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    aluCore u_aluCore (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .illegal    (illegal)
    );

    bind aluCore aluCore_props u_props (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .wbValid    (wbValid),
        .illegal    (illegal)
    );

    ////////////////////////////////////////////////////////////////////////////
    // encoders and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa, input logic [5:0] fn);
        return {op, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rand16();
        return 16'($random(seed));
    endfunction

    function automatic expectT refModel(input logic [31:0] word);
        expectT                e;
        logic [5:0]            op;
        logic [5:0]            fn;
        logic [4:0]            sa;
        logic [`MIPS_XLEN-1:0] a;
        logic [`MIPS_XLEN-1:0] b;
        logic [`MIPS_XLEN-1:0] immS;
        logic [`MIPS_XLEN-1:0] immZ;
        logic signed [63:0]    prod;
        op     = word[31:26];
        fn     = word[5:0];
        sa     = word[10:6];
        a      = shadow[word[25:21]];
        b      = shadow[word[20:16]];
        immS   = {{16{word[15]}}, word[15:0]};
        immZ   = {16'h0000, word[15:0]};  // logic immediates
        prod   = $signed(a) * $signed(b);
        e      = '0;
        e.addr = word[15:11];  // rd for the register forms
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADD, FN_ADDU: e.data = a + b;
                    FN_SUB, FN_SUBU: e.data = a - b;
                    FN_AND:          e.data = a & b;
                    FN_OR:           e.data = a | b;
                    FN_XOR:          e.data = a ^ b;
                    FN_NOR:          e.data = ~(a | b);
                    FN_SLT:          e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU:         e.data = (a < b) ? 32'd1 : 32'd0;
                    default:         e.illegal = 1'b1;
                endcase
            end
            OP_SPECIAL2: begin
                if (fn == FN_MUL) begin
                    e.data = prod[31:0];
                end else begin
                    e.illegal = 1'b1;
                end
            end
            OP_SPECIAL3: begin
                if (fn == FN_BSHFL && sa == SA_SEB) begin
                    e.data = {{24{b[7]}}, b[7:0]};
                end else if (fn == FN_BSHFL && sa == SA_SEH) begin
                    e.data = {{16{b[15]}}, b[15:0]};
                end else begin
                    e.illegal = 1'b1;
                end
            end
            default: begin
                e.addr = word[20:16];  // immediate forms write rt
                case (op)
                    OP_ADDI, OP_ADDIU: e.data = a + immS;
                    OP_SLTI:  e.data = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
                    OP_SLTIU: e.data = (a < immS) ? 32'd1 : 32'd0;
                    OP_ANDI:  e.data = a & immZ;
                    OP_ORI:   e.data = a | immZ;
                    OP_XORI:  e.data = a ^ immZ;
                    default:  e.illegal = 1'b1;
                endcase
            end
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // drive, compare, report
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic issue(input logic [31:0] word);
        expectT e;
        @(negedge clk);
        e          = refModel(word);
        e.cycle    = cycleCount;
        instr      = word;
        instrValid = 1'b1;
        expQ.push_back(e);
        if (!e.illegal && e.addr != 0) begin
            shadow[e.addr] = e.data;
        end
    endtask

    task automatic endTest(input string name);
        @(negedge clk);
        instrValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        $display("test %s finished with %0d errors", name, errorCount - testErrStart);
        testErrStart = errorCount;
    endtask

    always @(negedge clk) begin : compare
        expectT e;
        if (wbValid || illegal) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("report at %0t with no instruction outstanding", $time);
            end else begin
                e = expQ.pop_front();
                if (cycleCount != e.cycle + 1) begin
                    errorCount++;
                    $display("report at %0t came %0d cycles after issue instead of one",
                             $time, cycleCount - e.cycle);
                end
                checkValue("illegal", e.illegal, illegal);
                checkValue("wbValid", !e.illegal, wbValid);
                if (!e.illegal) begin
                    checkValue("wbAddr", e.addr, wbAddr);
                    checkValue("wbData", e.data, wbData);
                end
            end
        end else if (expQ.size() != 0 && expQ[0].cycle + 1 <= cycleCount) begin
            e = expQ.pop_front();
            errorCount++;
            $display("no report at %0t for instruction issued in cycle %0d", $time, e.cycle);
        end
    end

    initial begin : watchdog
        #((TOTAL_INSTR + 20 + NUM_TESTS * 4 + RESET_CYCLES) * CLK_PERIOD * 2);
        $display("timeout at %0t, run did not complete", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        int assertFails;
        for (int i = 0; i < NREG; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // every register reads zero out of reset, r0 ignores writes
        for (int k = 1; k < NREG; k++) begin
            issue(rType(OP_SPECIAL, 5'(k), 5'd0, 5'(k), 5'd0, FN_OR));
        end
        issue(rType(OP_SPECIAL, 5'd0, 5'd0, 5'd1, 5'd0, FN_SLT));
        issue(iType(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        issue(rType(OP_SPECIAL, 5'd0, 5'd0, 5'd3, 5'd0, FN_OR));
        endTest("resetZero");

        for (int r = 0; r < ROUNDS_ARITH; r++) begin
            issue(iType(OP_ADDIU, 5'd0, 5'd4, rand16()));
            issue(iType(OP_ORI, 5'd4, 5'd4, rand16()));
            issue(iType(OP_ADDIU, 5'd0, 5'd5, rand16()));
            issue(iType(OP_ORI, 5'd5, 5'd5, rand16()));
            foreach (arithFn[i]) begin
                issue(rType(OP_SPECIAL, 5'd4, 5'd5, 5'(6 + i), 5'd0, arithFn[i]));
            end
        end
        endTest("registerArith");

        for (int r = 0; r < ROUNDS_IMM; r++) begin
            issue(iType(OP_ADDIU, 5'd0, 5'd7, rand16()));
            foreach (immOp[i]) begin
                issue(iType(immOp[i], 5'd7, 5'(8 + i), rand16() | 16'h8000));  // bit 15 set
            end
        end
        endTest("immediates");

        for (int r = 0; r < ROUNDS_MUL; r++) begin
            issue(iType(OP_ADDIU, 5'd0, 5'd16, rand16()));
            issue(iType(OP_ORI, 5'd16, 5'd16, rand16()));
            issue(iType(OP_ADDIU, 5'd0, 5'd17, rand16()));
            issue(iType(OP_ORI, 5'd17, 5'd17, rand16()));
            issue(rType(OP_SPECIAL2, 5'd16, 5'd17, 5'd18, 5'd0, FN_MUL));
            issue(rType(OP_SPECIAL2, 5'd18, 5'd18, 5'd19, 5'd0, FN_MUL));
            issue(rType(OP_SPECIAL3, 5'd0, 5'd19, 5'd20, SA_SEB, FN_BSHFL));
            issue(rType(OP_SPECIAL3, 5'd0, 5'd19, 5'd21, SA_SEH, FN_BSHFL));
            issue(rType(OP_SPECIAL3, 5'd0, 5'd16, 5'd22, SA_SEB, FN_BSHFL));
        end
        endTest("mulAndExtend");

        // each instruction consumes the previous result
        issue(iType(OP_ADDIU, 5'd0, 5'd1, rand16()));
        for (int r = 0; r < CHAIN_LEN; r++) begin
            issue(iType(OP_ADDIU, 5'd1, 5'd2, rand16()));
            issue(rType(OP_SPECIAL, 5'd2, 5'd1, 5'd1, 5'd0, FN_XOR));
        end
        endTest("backToBack");

        issue(iType(6'b100011, 5'd1, 5'd4, 16'h0010));   // lw
        issue(iType(6'b001111, 5'd0, 5'd5, 16'hbeef));   // lui
        issue(iType(6'b000100, 5'd1, 5'd2, 16'h0004));   // beq
        issue(rType(OP_SPECIAL, 5'd1, 5'd2, 5'd6, 5'd4, 6'b000000));    // sll
        issue(rType(OP_SPECIAL, 5'd1, 5'd2, 5'd7, 5'd0, 6'b011000));    // mult
        issue(rType(OP_SPECIAL2, 5'd1, 5'd2, 5'd8, 5'd0, 6'b000000));   // madd
        issue(rType(OP_SPECIAL3, 5'd0, 5'd2, 5'd9, 5'b00010, FN_BSHFL));  // wsbh
        issue(rType(OP_SPECIAL3, 5'd1, 5'd2, 5'd10, 5'd0, 6'b000000));  // ext
        for (int k = 1; k < NREG; k++) begin
            issue(rType(OP_SPECIAL, 5'(k), 5'd0, 5'(k), 5'd0, FN_OR));
        end
        endTest("illegalEncodings");

        assertFails = u_aluCore.u_props.failCount;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_TESTS, checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/ctrlIf.sv
rtl/datapathController.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/aluCore.sv
verif/aluCore_props.sv
verif/aluCoreTb.sv

// ==== Bender.yml ====
package:
  name: alu_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/ctrlIf.sv
      - rtl/datapathController.sv
      - rtl/regFile.sv
      - rtl/aluUnit.sv
      - rtl/aluCore.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/aluCore_props.sv
      - verif/aluCoreTb.sv
